// ==== common/host_word_if.sv ====
// decoded frame words from the framer to the data modules
// all signals are registered by the framer, no back-pressure exists
`timescale 1ns/100ps
`default_nettype none

interface host_word_if;
	import hps_cmd_pkg::*;

	logic       word_valid;
	host_cmd_t  cmd;
	word_idx_t  word_idx;
	host_word_t word;
	logic       frame_start;
	logic       frame_end;

	modport framer (
		output word_valid, cmd, word_idx, word, frame_start, frame_end
	);

	modport sink (
		input word_valid, cmd, word_idx, word, frame_start, frame_end
	);

endinterface

`default_nettype wire

// ==== common/hps_cmd_pkg.sv ====
// word and command types of the host link
// only the commands handled by this core are listed, other codes are ignored
`default_nettype none

package hps_cmd_pkg;

	// one word as sent by the host
	typedef logic [15:0] host_word_t;

	// command codes, first word of a frame
	typedef enum logic [15:0] {
		CMD_JOY0       = 16'h0002,
		CMD_JOY1       = 16'h0003,
		CMD_KBD        = 16'h0005,
		CMD_STATUS     = 16'h001e,
		CMD_FILE_TX    = 16'h0053,
		CMD_FILE_DAT   = 16'h0054,
		CMD_FILE_INDEX = 16'h0055
	} host_cmd_t;

	// data word number inside a frame, sticks at the top value
	typedef logic [3:0] word_idx_t;

	localparam word_idx_t WORD_IDX_MAX = 4'hf;

endpackage

`default_nettype wire

// ==== common/hps_ps2_pkg.sv ====
// types of the emulated PS/2 keyboard transmitter
// pointer width follows the FIFO depth from the settings header
`default_nettype none

`include "hps_settings.svh"

package hps_ps2_pkg;

	// bit slot currently driven on the data line
	typedef enum logic [2:0] {IDLE, START, DATA, PARITY, STOP} ps2_tx_state_t;

	// read/write pointer, top bit tells full from empty
	typedef logic [`HPS_PS2_FIFO_BITS:0] fifo_ptr_t;

endpackage

`default_nettype wire

// ==== common/hps_settings.svh ====
// build constants for the host link and the PS/2 keyboard path
// the divider and idle wait are counted in clk_sys cycles and PS/2 ticks
// fifo depth is a power of two, given as log2
`ifndef HPS_SETTINGS_SVH
`define HPS_SETTINGS_SVH

////////////////////////////////////////////////////////////
// PS/2 timing
////////////////////////////////////////////////////////////

// clk_sys cycles per half period of the PS/2 clock
`define HPS_PS2_DIV 4

// rising ticks of idle bus required before a start bit
`define HPS_PS2_IDLE_TICKS 4

// log2 of the keyboard byte FIFO depth
`define HPS_PS2_FIFO_BITS 3

`endif

// ==== files.f ====
+incdir+common
common/hps_cmd_pkg.sv
common/hps_ps2_pkg.sv
common/host_word_if.sv
hw/host_frame_fsm.sv
hw/ctrl_regs.sv
hw/file_loader.sv
ps2/ps2_clk_div.sv
ps2/ps2_kbd_tx.sv
hw/hps_link_top.sv
tb/tb_hps_link.sv

// ==== hw/ctrl_regs.sv ====
// joystick and status registers
// joystick words 1 and 2 fill bits 15:0 and 31:16
// status takes words 1 to 4, lowest bits first, later words are dropped
`timescale 1ns/100ps
`default_nettype none

module ctrl_regs (
	input  wire         clk_sys,
	input  wire         reset,
	host_word_if.sink   bus,
	output logic [31:0] joystick_0,
	output logic [31:0] joystick_1,
	output logic [63:0] status
);
	import hps_cmd_pkg::*;

	// register select, decoded once per frame
	logic sel_joy0;
	logic sel_joy1;
	logic sel_status;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			sel_joy0 <= 1'b0;
			sel_joy1 <= 1'b0;
			sel_status <= 1'b0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status <= '0;
		end else begin
			if (bus.frame_start) begin
				sel_joy0 <= (bus.cmd == CMD_JOY0);
				sel_joy1 <= (bus.cmd == CMD_JOY1);
				sel_status <= (bus.cmd == CMD_STATUS);
			end else if (bus.frame_end) begin
				sel_joy0 <= 1'b0;
				sel_joy1 <= 1'b0;
				sel_status <= 1'b0;
			end

			if (bus.word_valid && sel_joy0) begin
				if (bus.word_idx == 4'd1)
					joystick_0[15:0] <= bus.word;
				if (bus.word_idx == 4'd2)
					joystick_0[31:16] <= bus.word;
			end

			if (bus.word_valid && sel_joy1) begin
				if (bus.word_idx == 4'd1)
					joystick_1[15:0] <= bus.word;
				if (bus.word_idx == 4'd2)
					joystick_1[31:16] <= bus.word;
			end

			if (bus.word_valid && sel_status) begin
				case (bus.word_idx)
					4'd1: status[15:0] <= bus.word;
					4'd2: status[31:16] <= bus.word;
					4'd3: status[47:32] <= bus.word;
					4'd4: status[63:48] <= bus.word;
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/file_loader.sv ====
// file download to the core, byte wide, address steps by one
// a start word with a nonzero low byte opens a download and rewinds the address
// ioctl_wr pulses two cycles after the data strobe
`timescale 1ns/100ps
`default_nettype none

module file_loader (
	input  wire         clk_sys,
	input  wire         reset,
	host_word_if.sink   bus,
	output logic        ioctl_download,
	output logic [7:0]  ioctl_index,
	output logic        ioctl_wr,
	output logic [26:0] ioctl_addr,
	output logic [7:0]  ioctl_dout
);
	import hps_cmd_pkg::*;

	// address of the next byte
	logic [26:0] addr;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			ioctl_download <= 1'b0;
			ioctl_index <= '0;
			ioctl_wr <= 1'b0;
			ioctl_addr <= '0;
			ioctl_dout <= '0;
			addr <= '0;
		end else begin
			ioctl_wr <= 1'b0;
			if (bus.word_valid) begin
				case (bus.cmd)
					CMD_FILE_INDEX: ioctl_index <= bus.word[7:0];
					CMD_FILE_TX: begin
						if (bus.word[7:0] != 8'h00) begin
							ioctl_download <= 1'b1;
							addr <= '0;
						end else begin
							ioctl_download <= 1'b0;
						end
					end
					CMD_FILE_DAT: begin
						ioctl_wr <= 1'b1;
						ioctl_addr <= addr;
						ioctl_dout <= bus.word[7:0];
						addr <= addr + 27'd1;
					end
					default: ;
				endcase
			end
		end
	end

	// host must open the download before sending data
	a_wr_in_download: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wr |-> ioctl_download);

endmodule

`default_nettype wire

// ==== hw/host_frame_fsm.sv ====
// host framing, a frame lasts while io_enable is high
// the first strobed word is the command, the rest are numbered from 1
// every output appears one clk_sys cycle after its strobe
`timescale 1ns/100ps
`default_nettype none

module host_frame_fsm (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire                     io_enable,
	input  wire                     io_strobe,
	input  hps_cmd_pkg::host_word_t io_din,
	host_word_if.framer             bus
);
	import hps_cmd_pkg::*;

	typedef enum logic [1:0] {IDLE, WAIT_CMD, DATA} frame_state_t;

	frame_state_t state;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state <= IDLE;
			bus.word_valid <= 1'b0;
			bus.frame_start <= 1'b0;
			bus.frame_end <= 1'b0;
			bus.cmd <= host_cmd_t'(16'h0000);
			bus.word_idx <= '0;
			bus.word <= '0;
		end else begin
			bus.word_valid <= 1'b0;
			bus.frame_start <= 1'b0;
			bus.frame_end <= 1'b0;
			if (!io_enable) begin
				if (state != IDLE)
					bus.frame_end <= 1'b1;
				state <= IDLE;
			end else if (io_strobe) begin
				if (state == DATA) begin
					bus.word_valid <= 1'b1;
					bus.word <= io_din;
					if (bus.word_idx != WORD_IDX_MAX)
						bus.word_idx <= bus.word_idx + 4'd1;
				end else begin
					// command word opens the data phase
					bus.cmd <= host_cmd_t'(io_din);
					bus.word_idx <= '0;
					bus.frame_start <= 1'b1;
					state <= DATA;
				end
			end else if (state == IDLE) begin
				state <= WAIT_CMD;
			end
		end
	end

	// a data word always comes from a strobe inside an open frame
	a_valid_in_frame: assert property (@(posedge clk_sys) disable iff (reset)
		bus.word_valid |-> $past(io_enable && io_strobe));

endmodule

`default_nettype wire

// ==== hw/hps_link_top.sv ====
// host command link top level
// keyboard FIFO depth and PS/2 rate come from the settings header
`timescale 1ns/100ps
`default_nettype none

module hps_link_top (
	input  wire         clk_sys,
	input  wire         reset,
	input  wire         io_enable,
	input  wire         io_strobe,
	input  wire  [15:0] io_din,
	output wire  [31:0] joystick_0,
	output wire  [31:0] joystick_1,
	output wire  [63:0] status,
	output wire         ioctl_download,
	output wire  [7:0]  ioctl_index,
	output wire         ioctl_wr,
	output wire  [26:0] ioctl_addr,
	output wire  [7:0]  ioctl_dout,
	input  wire         ps2_kbd_clk_in,
	output wire         ps2_kbd_clk_out,
	output wire         ps2_kbd_data_out
);

	wire ps2_rise;
	wire ps2_fall;

	host_word_if link ();

	host_frame_fsm u_framer (
		.clk_sys(clk_sys), .reset(reset),
		.io_enable(io_enable), .io_strobe(io_strobe), .io_din(io_din),
		.bus(link.framer)
	);

	ctrl_regs u_regs (
		.clk_sys(clk_sys), .reset(reset), .bus(link.sink),
		.joystick_0(joystick_0), .joystick_1(joystick_1), .status(status)
	);

	file_loader u_loader (
		.clk_sys(clk_sys), .reset(reset), .bus(link.sink),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout)
	);

	ps2_clk_div u_ps2_div (
		.clk_sys(clk_sys), .reset(reset),
		.rise_tick(ps2_rise), .fall_tick(ps2_fall)
	);

	ps2_kbd_tx u_kbd (
		.clk_sys(clk_sys), .reset(reset), .bus(link.sink),
		.rise_tick(ps2_rise), .fall_tick(ps2_fall),
		.ps2_kbd_clk_in(ps2_kbd_clk_in),
		.ps2_kbd_clk_out(ps2_kbd_clk_out), .ps2_kbd_data_out(ps2_kbd_data_out)
	);

endmodule

`default_nettype wire

// ==== ps2/ps2_clk_div.sv ====
// PS/2 bit clock timer
// rise and fall ticks alternate, one every div clk_sys cycles
// div must be at least 2
`timescale 1ns/100ps
`default_nettype none

`include "hps_settings.svh"

module ps2_clk_div #(
	parameter int div = `HPS_PS2_DIV
) (
	input  wire  clk_sys,
	input  wire  reset,
	output logic rise_tick,
	output logic fall_tick
);

	localparam int cnt_w = $clog2(div);

	logic [cnt_w-1:0] cnt;
	logic             phase;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cnt <= '0;
			phase <= 1'b0;
			rise_tick <= 1'b0;
			fall_tick <= 1'b0;
		end else begin
			rise_tick <= 1'b0;
			fall_tick <= 1'b0;
			if (cnt == cnt_w'(div - 1)) begin
				cnt <= '0;
				phase <= ~phase;
				// tick matches the phase being entered
				rise_tick <= ~phase;
				fall_tick <= phase;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== ps2/ps2_kbd_tx.sv ====
// emulated PS/2 keyboard transmitter
// bytes from CMD_KBD frames queue in a FIFO, a full FIFO drops new bytes
// frame is start 0, 8 data bits LSB first, odd parity, stop 1
// a host holding the clock low delays the next byte, never the current one
`timescale 1ns/100ps
`default_nettype none

`include "hps_settings.svh"

module ps2_kbd_tx #(
	parameter int fifo_bits = `HPS_PS2_FIFO_BITS
) (
	input  wire       clk_sys,
	input  wire       reset,
	host_word_if.sink bus,
	input  wire       rise_tick,
	input  wire       fall_tick,
	input  wire       ps2_kbd_clk_in,
	output logic      ps2_kbd_clk_out,
	output logic      ps2_kbd_data_out
);
	import hps_cmd_pkg::*;
	import hps_ps2_pkg::*;

	localparam int idle_w = $clog2(`HPS_PS2_IDLE_TICKS + 1);

	logic [7:0]  fifo_mem [0:(1 << fifo_bits) - 1];
	fifo_ptr_t   wr_ptr;
	fifo_ptr_t   rd_ptr;
	logic        push;
	logic        empty;
	logic        full;

	ps2_tx_state_t     state;
	logic [idle_w-1:0] idle_cnt;
	logic [2:0]        bit_cnt;
	logic [7:0]        shift;
	logic              parity;

	//////////////////////////////////////////////////////////////
	// byte FIFO
	//////////////////////////////////////////////////////////////

	assign push  = bus.word_valid && (bus.cmd == CMD_KBD);
	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[fifo_bits] != rd_ptr[fifo_bits]) &&
		(wr_ptr[fifo_bits-1:0] == rd_ptr[fifo_bits-1:0]);

	always_ff @(posedge clk_sys) begin
		if (push && !full)
			fifo_mem[wr_ptr[fifo_bits-1:0]] <= bus.word[7:0];
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset)
			wr_ptr <= '0;
		else if (push && !full)
			wr_ptr <= wr_ptr + 1'b1;
	end

	//////////////////////////////////////////////////////////////
	// serializer, bits change on rise ticks
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state <= IDLE;
			rd_ptr <= '0;
			idle_cnt <= '0;
			bit_cnt <= '0;
			shift <= '0;
			parity <= 1'b0;
			ps2_kbd_clk_out <= 1'b1;
			ps2_kbd_data_out <= 1'b1;
		end else begin
			if (fall_tick && state != IDLE)
				ps2_kbd_clk_out <= 1'b0;
			if (rise_tick) begin
				ps2_kbd_clk_out <= 1'b1;
				case (state)
					IDLE: begin
						if (empty || !ps2_kbd_clk_in) begin
							idle_cnt <= '0;
						end else if (idle_cnt == idle_w'(`HPS_PS2_IDLE_TICKS - 1)) begin
							// bus idle long enough, put out the start bit
							shift <= fifo_mem[rd_ptr[fifo_bits-1:0]];
							parity <= ~^fifo_mem[rd_ptr[fifo_bits-1:0]];
							rd_ptr <= rd_ptr + 1'b1;
							idle_cnt <= '0;
							ps2_kbd_data_out <= 1'b0;
							state <= START;
						end else begin
							idle_cnt <= idle_cnt + 1'b1;
						end
					end
					START: begin
						ps2_kbd_data_out <= shift[0];
						shift <= shift >> 1;
						bit_cnt <= '0;
						state <= DATA;
					end
					DATA: begin
						if (bit_cnt == 3'd7) begin
							ps2_kbd_data_out <= parity;
							state <= PARITY;
						end else begin
							ps2_kbd_data_out <= shift[0];
							shift <= shift >> 1;
							bit_cnt <= bit_cnt + 3'd1;
						end
					end
					PARITY: begin
						ps2_kbd_data_out <= 1'b1;
						state <= STOP;
					end
					default: state <= IDLE;
				endcase
			end
		end
	end

	// the host link has no back-pressure, the host must pace keyboard bytes
	a_no_push_full: assert property (@(posedge clk_sys) disable iff (reset)
		push |-> !full);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the host link testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_hps_link -o tb_hps_link -f files.f

out=$(./obj_dir/tb_hps_link 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "test passed"; then
	exit 0
fi
exit 1

// ==== tb/tb_hps_link.sv ====
// testbench for the host command link
// frames come from a table, data words are random with a fixed seed
// a PS/2 receiver model decodes frames on the falling edge of ps2_kbd_clk_out
// the run stops at the first mismatch
`timescale 1ns/100ps
`default_nettype none

`include "hps_settings.svh"

module tb_hps_link;
	import hps_cmd_pkg::*;

	localparam int n_rows = 11;
	localparam int max_words = 6;
	// clk_sys cycles for one PS/2 byte, idle wait included
	localparam int byte_cycles = (11 + `HPS_PS2_IDLE_TICKS + 1) * 2 * `HPS_PS2_DIV;

	// expected result kind of a row
	localparam int k_joy = 0;
	localparam int k_status = 1;
	localparam int k_index = 2;
	localparam int k_start = 3;
	localparam int k_data = 4;
	localparam int k_stop = 5;
	localparam int k_kbd = 6;
	localparam int k_inhibit = 7;

	logic        clk_sys;
	logic        reset;
	logic        io_enable;
	logic        io_strobe;
	logic [15:0] io_din;
	logic [31:0] joystick_0;
	logic [31:0] joystick_1;
	logic [63:0] status;
	logic        ioctl_download;
	logic [7:0]  ioctl_index;
	logic        ioctl_wr;
	logic [26:0] ioctl_addr;
	logic [7:0]  ioctl_dout;
	logic        ps2_kbd_clk_in;
	logic        ps2_kbd_clk_out;
	logic        ps2_kbd_data_out;

	logic [15:0] tbl_cmd [n_rows];
	int          tbl_len [n_rows];
	int          tbl_kind [n_rows];
	logic [15:0] tbl_words [n_rows][max_words];

	// reference state
	logic [31:0] exp_joy [2];
	logic [63:0] exp_status;
	logic [7:0]  exp_index;
	logic        exp_download;
	logic [26:0] exp_addr;
	logic [26:0] wr_addr_q [$];
	logic [7:0]  wr_data_q [$];
	logic [7:0]  kbd_q [$];
	logic [26:0] next_wr_addr;
	logic [7:0]  next_wr_data;
	int          exp_wr_total;
	int          wr_count = 0;

	// PS/2 receiver model
	logic [10:0] rx_shift;
	logic [10:0] rx_frames [$];
	int          rx_bits = 0;
	int          rx_falls = 0;

	integer seed;
	int     limit_cycles = 0;
	int     falls_before;

	hps_link_top dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		if (got !== expected) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, expected);
			$display("test failed");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("test failed");
		$fatal(1, "stopped at first error");
	endtask

	////////////////////////////////////////////////////////////
	// stimulus table
	////////////////////////////////////////////////////////////

	task automatic set_row(input int r, input logic [15:0] cmd, input int len, input int kind);
		tbl_cmd[r] = cmd;
		tbl_len[r] = len;
		tbl_kind[r] = kind;
	endtask

	task automatic build_table();
		logic [31:0] rnd;
		for (int r = 0; r < n_rows; r++) begin
			for (int i = 0; i < max_words; i++) begin
				rnd = $random(seed);
				tbl_words[r][i] = rnd[15:0];
			end
		end
		set_row(0, CMD_JOY0, 2, k_joy);
		set_row(1, CMD_JOY1, 2, k_joy);
		set_row(2, CMD_JOY0, 2, k_joy);
		// fifth word must be ignored
		set_row(3, CMD_STATUS, 5, k_status);
		set_row(4, CMD_FILE_INDEX, 1, k_index);
		set_row(5, CMD_FILE_TX, 1, k_start);
		set_row(6, CMD_FILE_DAT, 6, k_data);
		set_row(7, CMD_FILE_DAT, 3, k_data);
		set_row(8, CMD_FILE_TX, 1, k_stop);
		set_row(9, CMD_KBD, 3, k_kbd);
		set_row(10, CMD_KBD, 1, k_inhibit);
		// only the low byte decides start or stop
		tbl_words[5][0][0] = 1'b1;
		tbl_words[8][0][7:0] = 8'h00;
	endtask

	// update the reference model for one row
	task automatic expect_row(input int r);
		int j;
		case (tbl_kind[r])
			k_joy: begin
				j = (tbl_cmd[r] == CMD_JOY1) ? 1 : 0;
				exp_joy[j] = {tbl_words[r][1], tbl_words[r][0]};
			end
			k_status: begin
				for (int i = 0; i < tbl_len[r] && i < 4; i++)
					exp_status[16*i +: 16] = tbl_words[r][i];
			end
			k_index: exp_index = tbl_words[r][0][7:0];
			k_start: begin
				exp_download = 1'b1;
				exp_addr = '0;
			end
			k_data: begin
				for (int i = 0; i < tbl_len[r]; i++) begin
					wr_addr_q.push_back(exp_addr);
					wr_data_q.push_back(tbl_words[r][i][7:0]);
					exp_addr = exp_addr + 27'd1;
					exp_wr_total++;
				end
			end
			k_stop: exp_download = 1'b0;
			default: begin
				for (int i = 0; i < tbl_len[r]; i++)
					kbd_q.push_back(tbl_words[r][i][7:0]);
			end
		endcase
	endtask

	task automatic send_frame(input int r);
		@(negedge clk_sys);
		io_enable = 1'b1;
		io_strobe = 1'b1;
		io_din = tbl_cmd[r];
		for (int i = 0; i < tbl_len[r]; i++) begin
			@(negedge clk_sys);
			io_din = tbl_words[r][i];
		end
		@(negedge clk_sys);
		io_strobe = 1'b0;
		io_enable = 1'b0;
		io_din = '0;
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic check_regs();
		check_value("joystick_0", 64'(joystick_0), 64'(exp_joy[0]));
		check_value("joystick_1", 64'(joystick_1), 64'(exp_joy[1]));
		check_value("status", status, exp_status);
		check_value("ioctl_index", 64'(ioctl_index), 64'(exp_index));
		check_value("ioctl_download", 64'(ioctl_download), 64'(exp_download));
		check_value("ioctl_wr count", 64'(wr_count), 64'(exp_wr_total));
	endtask

	// one received serial frame per expected keyboard byte, in order
	task automatic check_kbd();
		logic [10:0] f;
		logic [7:0]  b;
		while (kbd_q.size() > 0) begin
			while (rx_frames.size() == 0)
				@(negedge clk_sys);
			f = rx_frames.pop_front();
			b = kbd_q.pop_front();
			check_value("ps2 start bit", 64'(f[0]), 64'(0));
			check_value("ps2 data byte", 64'(f[8:1]), 64'(b));
			check_value("ps2 ones over data and parity", 64'(^f[9:1]), 64'(1));
			check_value("ps2 stop bit", 64'(f[10]), 64'(1));
		end
	endtask

	////////////////////////////////////////////////////////////
	// monitors
	////////////////////////////////////////////////////////////

	always @(negedge ps2_kbd_clk_out) begin
		rx_falls++;
		rx_shift[rx_bits] = ps2_kbd_data_out;
		rx_bits++;
		if (rx_bits == 11) begin
			rx_frames.push_back(rx_shift);
			rx_bits = 0;
		end
	end

	always @(negedge clk_sys) begin
		if (!reset && ioctl_wr === 1'b1) begin
			if (wr_addr_q.size() == 0) begin
				fail_run("ioctl_wr pulsed with no download byte pending");
			end else begin
				next_wr_addr = wr_addr_q.pop_front();
				next_wr_data = wr_data_q.pop_front();
				check_value("ioctl_download", 64'(ioctl_download), 64'(1));
				check_value("ioctl_addr", 64'(ioctl_addr), 64'(next_wr_addr));
				check_value("ioctl_dout", 64'(ioctl_dout), 64'(next_wr_data));
				wr_count++;
			end
		end
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk_sys);
		$display("watchdog expired after %0d cycles, the DUT did not finish", limit_cycles);
		$display("test failed");
		$fatal(1, "timeout");
	end

	initial begin
		int total_cycles;
		int kbd_bytes;
		reset = 1'b1;
		io_enable = 1'b0;
		io_strobe = 1'b0;
		io_din = '0;
		ps2_kbd_clk_in = 1'b1;
		seed = 32'h671;
		exp_joy[0] = '0;
		exp_joy[1] = '0;
		exp_status = '0;
		exp_index = '0;
		exp_download = 1'b0;
		exp_addr = '0;
		exp_wr_total = 0;
		build_table();

		total_cycles = 0;
		kbd_bytes = 0;
		for (int r = 0; r < n_rows; r++) begin
			total_cycles += tbl_len[r] + 5;
			if (tbl_kind[r] == k_kbd || tbl_kind[r] == k_inhibit)
				kbd_bytes += tbl_len[r];
		end
		// extra two bytes of time cover the inhibit window
		limit_cycles = 2 * (8 + total_cycles + byte_cycles * (kbd_bytes + 2));

		repeat (8) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);
		check_value("ioctl_wr", 64'(ioctl_wr), 64'(0));
		check_value("ps2_kbd_clk_out", 64'(ps2_kbd_clk_out), 64'(1));
		check_value("ps2_kbd_data_out", 64'(ps2_kbd_data_out), 64'(1));
		check_regs();

		for (int r = 0; r < n_rows; r++) begin
			expect_row(r);
			if (tbl_kind[r] == k_inhibit) begin
				ps2_kbd_clk_in = 1'b0;
				falls_before = rx_falls;
			end
			send_frame(r);
			check_regs();
			if (tbl_kind[r] == k_kbd)
				check_kbd();
			if (tbl_kind[r] == k_inhibit) begin
				repeat (2 * byte_cycles) @(negedge clk_sys);
				check_value("ps2_kbd_clk_out falls while inhibited",
					64'(rx_falls), 64'(falls_before));
				ps2_kbd_clk_in = 1'b1;
				check_kbd();
			end
		end

		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire
